// File: source/battle_pkg.sv
`default_nettype none

package battle_pkg;

  localparam int GRID_DIM  = 8;   // Board edge, cells
  localparam int NUM_SHIPS = 5;   // One fleet slot per ship type

  typedef logic [2:0] coord_t;

  // x sits in the low bits, as in the stored record
  typedef struct packed {
    coord_t y;
    coord_t x;
  } cell_t;

  typedef enum logic [2:0] {
    carrier    = 3'd0,
    battleship = 3'd1,
    seaplane   = 3'd2,
    cruiser    = 3'd3,
    submarine  = 3'd4
  } ship_type_e;  // Codes 5 to 7 are not ships

  typedef struct packed {
    logic [2:0]  remaining;  // Cells still afloat
    cell_t [4:0] cells;      // Cell 0 is the anchor, unused cells zero
    ship_type_e  ship_type;
  } ship_rec_t;

  typedef struct packed {
    ship_type_e ship_type;
    logic       vertical;
    logic [1:0] orient;      // Seaplane shape select
    cell_t      anchor;
  } place_req_t;

  typedef enum logic [2:0] {
    place_ok,
    place_border,
    place_overlap,
    place_duplicate,
    place_bad_type
  } place_status_e;

  typedef enum logic [1:0] {
    shot_miss,
    shot_hit,
    shot_sunk,
    shot_repeat
  } shot_result_e;

  typedef struct packed {
    shot_result_e result;
    logic         fleet_sunk;
  } shot_rsp_t;

  // Cells per ship, zero for an invalid code
  function automatic logic [2:0] ship_len(ship_type_e t);
    case (t)
      carrier:    return 3'd5;
      battleship: return 3'd4;
      seaplane:   return 3'd3;
      cruiser:    return 3'd2;
      submarine:  return 3'd1;
      default:    return 3'd0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: source/ship_shape_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ship_shape_gen import battle_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             load,
  input  wire place_req_t req,
  output ship_rec_t       rec,
  output logic            border_ok,
  output logic            type_ok
);

  localparam coord_t EDGE = coord_t'(GRID_DIM - 1);  // Last legal coordinate

  coord_t      ax;
  coord_t      ay;
  logic [2:0]  len;
  logic [3:0]  reach;       // One past the last cell of a straight run
  cell_t [4:0] cells;
  logic        fits;
  logic        valid_type;

  assign ax         = req.anchor.x;
  assign ay         = req.anchor.y;
  assign len        = ship_len(req.ship_type);
  assign reach      = {1'b0, (req.vertical ? ay : ax)} + {1'b0, len};
  assign valid_type = (req.ship_type <= submarine);

  always_comb begin
    cells = '0;
    fits  = 1'b0;
    case (req.ship_type)
      carrier, battleship, cruiser: begin
        for (int i = 0; i < 5; i++) begin
          if (i < int'(len)) begin
            cells[i].x = req.vertical ? ax : ax + coord_t'(i);
            cells[i].y = req.vertical ? ay + coord_t'(i) : ay;
          end
        end
        fits = (reach <= 4'(GRID_DIM));
      end
      seaplane: begin
        // Vertical flag plays no part here
        cells[0] = req.anchor;
        case (req.orient)
          2'd0: begin
            cells[1] = '{y: ay + 3'd1, x: ax + 3'd1};
            cells[2] = '{y: ay, x: ax + 3'd2};
            fits     = (ax <= EDGE - 3'd2) && (ay <= EDGE - 3'd1);
          end
          2'd1: begin
            cells[1] = '{y: ay - 3'd1, x: ax + 3'd1};
            cells[2] = '{y: ay, x: ax + 3'd2};
            fits     = (ax <= EDGE - 3'd2) && (ay >= 3'd1);
          end
          2'd2: begin
            cells[1] = '{y: ay + 3'd1, x: ax + 3'd1};
            cells[2] = '{y: ay + 3'd2, x: ax};
            fits     = (ax <= EDGE - 3'd1) && (ay <= EDGE - 3'd2);
          end
          default: begin
            cells[1] = '{y: ay + 3'd1, x: ax - 3'd1};
            cells[2] = '{y: ay + 3'd2, x: ax};
            fits     = (ax >= 3'd1) && (ay <= EDGE - 3'd2);
          end
        endcase
      end
      submarine: begin
        cells[0] = req.anchor;
        fits     = 1'b1;   // Single cell always lands on the board
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      border_ok <= 1'b0;
      type_ok   <= 1'b0;
    end else if (load) begin
      border_ok <= fits;
      type_ok   <= valid_type;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rec <= '{remaining: len, cells: cells, ship_type: req.ship_type};
    end
  end

endmodule

`default_nettype wire

// File: source/occupancy_grid.sv
`timescale 1ns/100ps
`default_nettype none

module occupancy_grid import battle_pkg::*; #(
  parameter int N_CELLS = GRID_DIM * GRID_DIM
) (
  input  wire            clk,
  input  wire            rst_n,
  input  wire ship_rec_t cand,
  output logic           overlap,
  input  wire            commit,
  input  wire            shot_lookup,
  input  wire cell_t     shot_cell,
  output ship_type_e     owner,
  output logic           owned,
  output logic           was_shot
);

  localparam int IW = $clog2(N_CELLS);

  ship_type_e        owner_tbl [N_CELLS];
  logic [N_CELLS-1:0] owned_map;   // Valid bit per owner entry
  logic [N_CELLS-1:0] shot_map;
  logic [2:0]        cand_len;
  logic [IW-1:0]     shot_idx;

  function automatic logic [IW-1:0] cell_idx(cell_t c);
    return IW'(int'(c.y) * GRID_DIM + int'(c.x));
  endfunction

  assign cand_len = ship_len(cand.ship_type);
  assign shot_idx = cell_idx(shot_cell);

  // Live cells of the candidate against the current owners
  always_comb begin
    overlap = 1'b0;
    for (int i = 0; i < 5; i++) begin
      if (i < int'(cand_len) && owned_map[cell_idx(cand.cells[i])]) begin
        overlap = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owned_map <= '0;
      shot_map  <= '0;
      owned     <= 1'b0;
      was_shot  <= 1'b0;
    end else begin
      if (commit) begin
        for (int i = 0; i < 5; i++) begin
          if (i < int'(cand_len)) owned_map[cell_idx(cand.cells[i])] <= 1'b1;
        end
      end
      if (shot_lookup) begin
        owned              <= owned_map[shot_idx];
        was_shot           <= shot_map[shot_idx];
        shot_map[shot_idx] <= 1'b1;  // Marked on the lookup edge
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      for (int i = 0; i < 5; i++) begin
        if (i < int'(cand_len)) owner_tbl[cell_idx(cand.cells[i])] <= cand.ship_type;
      end
    end
    if (shot_lookup) owner <= owner_tbl[shot_idx];
  end

endmodule

`default_nettype wire

// File: source/fleet_memory.sv
`timescale 1ns/100ps
`default_nettype none

module fleet_memory import battle_pkg::*; #(
  parameter int N_SLOTS = NUM_SHIPS
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                wr_en,
  input  wire ship_rec_t     wr_rec,
  input  wire                hit_en,
  input  wire ship_type_e    hit_slot,
  output logic [N_SLOTS-1:0] placed,
  output logic [N_SLOTS-1:0] afloat,
  output logic               sunk_now
);

  ship_rec_t recs [N_SLOTS];   // Addressed by ship type
  ship_rec_t hit_rec;
  logic      last_cell;

  assign hit_rec   = recs[hit_slot];
  assign last_cell = (hit_rec.remaining == 3'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      placed   <= '0;
      afloat   <= '0;
      sunk_now <= 1'b0;
    end else begin
      sunk_now <= hit_en && last_cell;
      if (wr_en) begin
        placed[wr_rec.ship_type] <= 1'b1;
        afloat[wr_rec.ship_type] <= (wr_rec.remaining != 3'd0);
      end
      if (hit_en && last_cell) afloat[hit_slot] <= 1'b0;
    end
  end

  // Read-modify-write of the hit slot in one cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      recs[wr_rec.ship_type] <= wr_rec;
    end else if (hit_en && hit_rec.remaining != 3'd0) begin
      recs[hit_slot].remaining <= hit_rec.remaining - 3'd1;
    end
  end

endmodule

`default_nettype wire

// File: source/placement_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module placement_ctrl import battle_pkg::*; #(
  parameter int N_SLOTS = NUM_SHIPS
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                place_strobe,
  input  wire place_req_t    place_req,
  output logic               shape_load,
  input  wire ship_rec_t     shape_rec,
  input  wire                border_ok,
  input  wire                type_ok,
  input  wire                overlap,
  input  wire [N_SLOTS-1:0]  placed,
  output logic               grid_commit,
  output logic               mem_wr,
  output logic               place_done,
  output place_status_e      place_status,
  output logic               busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_check,
    st_report
  } state_e;

  state_e        state;
  place_status_e status_d;
  logic          accept;
  logic          dup_q;       // Type already in the fleet
  logic [7:0]    placed_ext;  // Codes 5 to 7 read as not placed

  assign busy       = (state != st_idle) || place_done;
  assign accept     = place_strobe && !busy;
  assign shape_load = accept;
  assign placed_ext = 8'(placed);

  // Status priority: bad type, border, duplicate, overlap
  always_comb begin
    if (!type_ok || shape_rec.remaining == 3'd0) begin
      status_d = place_bad_type;
    end else if (!border_ok) begin
      status_d = place_border;
    end else if (dup_q) begin
      status_d = place_duplicate;
    end else if (overlap) begin
      status_d = place_overlap;
    end else begin
      status_d = place_ok;
    end
  end

  assign grid_commit = (state == st_check) && (status_d == place_ok);
  assign mem_wr      = grid_commit;  // Grid and fleet commit together

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= st_idle;
      dup_q        <= 1'b0;
      place_done   <= 1'b0;
      place_status <= place_ok;
    end else begin
      place_done <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            // Placed flags cannot move while this request is in flight
            dup_q <= placed_ext[place_req.ship_type];
            state <= st_check;
          end
        end
        st_check: begin
          place_status <= status_d;
          state        <= st_report;
        end
        st_report: begin
          place_done <= 1'b1;
          state      <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/shot_resolver.sv
`timescale 1ns/100ps
`default_nettype none

module shot_resolver import battle_pkg::*; #(
  parameter int N_SLOTS = NUM_SHIPS
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                fire_strobe,
  input  wire cell_t         fire_cell,
  input  wire                place_busy,
  output logic               grid_lookup,
  input  wire ship_type_e    owner,
  input  wire                owned,
  input  wire                was_shot,
  output logic               hit_en,
  output ship_type_e         hit_slot,
  input  wire                sunk_now,
  input  wire [N_SLOTS-1:0]  afloat,
  input  wire [N_SLOTS-1:0]  placed,
  output logic               shot_done,
  output shot_rsp_t          shot_rsp,
  output logic               shot_busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_hit,
    st_report
  } state_e;

  state_e       state;
  shot_result_e result_d;
  logic         fleet_d;
  logic         accept;

  assign shot_busy   = (state != st_idle) || shot_done;
  assign accept      = fire_strobe && !place_busy && !shot_busy;  // Placement wins a tie
  assign grid_lookup = accept;

  // First hit on an owned cell costs the ship one cell
  assign hit_en   = (state == st_hit) && owned && !was_shot;
  assign hit_slot = owner;

  always_comb begin
    if (was_shot) begin
      result_d = shot_repeat;
    end else if (!owned) begin
      result_d = shot_miss;
    end else if (sunk_now) begin
      result_d = shot_sunk;
    end else begin
      result_d = shot_hit;
    end
  end

  assign fleet_d = (afloat == '0) && (&placed);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= st_idle;
      shot_done <= 1'b0;
      shot_rsp  <= '{result: shot_miss, fleet_sunk: 1'b0};
    end else begin
      shot_done <= 1'b0;
      case (state)
        st_idle:   if (accept) state <= st_hit;
        st_hit:    state <= st_report;
        st_report: begin
          shot_rsp  <= '{result: result_d, fleet_sunk: fleet_d};
          shot_done <= 1'b1;
          state     <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/battle_map_top.sv
`timescale 1ns/100ps
`default_nettype none

module battle_map_top import battle_pkg::*; #(
  parameter int N_SLOTS = NUM_SHIPS,
  parameter int N_CELLS = GRID_DIM * GRID_DIM
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             place_strobe,
  input  wire place_req_t place_req,
  input  wire             fire_strobe,
  input  wire cell_t      fire_cell,
  output logic            place_done,
  output place_status_e   place_status,
  output logic            shot_done,
  output shot_rsp_t       shot_rsp,
  output logic            busy
);

  logic               shape_load;
  ship_rec_t          shape_rec;
  logic               border_ok;
  logic               type_ok;
  logic               overlap;
  logic               grid_commit;
  logic               mem_wr;
  logic               grid_lookup;
  ship_type_e         owner;
  logic               owned;
  logic               was_shot;
  logic               hit_en;
  ship_type_e         hit_slot;
  logic [N_SLOTS-1:0] placed;
  logic [N_SLOTS-1:0] afloat;
  logic               sunk_now;
  logic               place_busy;
  logic               shot_busy;
  wire                place_go;     // Placement strobe outside a shot
  wire                place_claim;  // Placement holds or takes the board

  assign place_go    = place_strobe && !shot_busy;
  assign place_claim = place_busy || place_go;
  assign busy        = place_busy || shot_busy;

  ship_shape_gen u_shape (
    .clk, .rst_n,
    .load      (shape_load),
    .req       (place_req),
    .rec       (shape_rec),
    .border_ok (border_ok),
    .type_ok   (type_ok)
  );

  occupancy_grid #(.N_CELLS(N_CELLS)) u_grid (
    .clk, .rst_n,
    .cand (shape_rec), .overlap (overlap), .commit (grid_commit),
    .shot_lookup (grid_lookup), .shot_cell (fire_cell),
    .owner (owner), .owned (owned), .was_shot (was_shot)
  );

  fleet_memory #(.N_SLOTS(N_SLOTS)) u_fleet (
    .clk, .rst_n,
    .wr_en (mem_wr), .wr_rec (shape_rec),
    .hit_en (hit_en), .hit_slot (hit_slot),
    .placed (placed), .afloat (afloat), .sunk_now (sunk_now)
  );

  placement_ctrl #(.N_SLOTS(N_SLOTS)) u_place (
    .clk, .rst_n,
    .place_strobe (place_go), .place_req (place_req), .shape_load (shape_load),
    .shape_rec (shape_rec), .border_ok (border_ok), .type_ok (type_ok),
    .overlap (overlap), .placed (placed), .grid_commit (grid_commit), .mem_wr (mem_wr),
    .place_done (place_done), .place_status (place_status), .busy (place_busy)
  );

  shot_resolver #(.N_SLOTS(N_SLOTS)) u_shot (
    .clk, .rst_n,
    .fire_strobe (fire_strobe), .fire_cell (fire_cell), .place_busy (place_claim),
    .grid_lookup (grid_lookup), .owner (owner), .owned (owned), .was_shot (was_shot),
    .hit_en (hit_en), .hit_slot (hit_slot), .sunk_now (sunk_now),
    .afloat (afloat), .placed (placed),
    .shot_done (shot_done), .shot_rsp (shot_rsp), .shot_busy (shot_busy)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_NS = 10   // Half of a 20 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: dv/battle_map_tb.sv
`timescale 1ns/100ps
`default_nettype none

module battle_map_tb import battle_pkg::*; ();

  localparam int TIMEOUT = 50;   // Cycles allowed for any wait

  logic          clk;
  logic          rst_n;
  logic          place_strobe;
  place_req_t    place_req;
  logic          fire_strobe;
  cell_t         fire_cell;
  logic          place_done;
  place_status_e place_status;
  logic          shot_done;
  shot_rsp_t     shot_rsp;
  logic          busy;

  // Board model
  int        owner_m [8][8];   // Ship type per cell or -1 for open water
  bit        shot_m [8][8];
  bit        placed_m [5];
  int        remain_m [5];
  int        sh_x [5];
  int        sh_y [5];
  int        sh_n;
  bit        sh_fits;
  shot_rsp_t last_rsp;
  int        errors;
  int        checks;

  tb_clock_gen #(.HALF_NS(10)) u_clk (.clk(clk));

  battle_map_top i_dut (
    .clk, .rst_n,
    .place_strobe, .place_req, .fire_strobe, .fire_cell,
    .place_done, .place_status, .shot_done, .shot_rsp, .busy
  );

  task automatic model_clear();
    for (int x = 0; x < 8; x++) begin
      for (int y = 0; y < 8; y++) begin
        owner_m[x][y] = -1;
        shot_m[x][y]  = 1'b0;
      end
    end
    for (int t = 0; t < 5; t++) begin
      placed_m[t] = 1'b0;
      remain_m[t] = 0;
    end
  endtask

  // Cells and border verdict of one request
  task automatic model_shape(input int t, input bit v, input int o, input int x, input int y);
    sh_n    = 0;
    sh_fits = 1'b0;
    for (int i = 0; i < 5; i++) begin
      sh_x[i] = x;
      sh_y[i] = y;
    end
    case (t)
      0, 1, 3: begin
        sh_n = (t == 0) ? 5 : (t == 1) ? 4 : 2;
        for (int i = 0; i < sh_n; i++) begin
          sh_x[i] = v ? x : x + i;
          sh_y[i] = v ? y + i : y;
        end
        sh_fits = ((v ? y : x) + sh_n) <= 8;
      end
      2: begin
        sh_n = 3;
        case (o)
          0: begin
            sh_x[1] = x + 1;
            sh_y[1] = y + 1;
            sh_x[2] = x + 2;
            sh_fits = (x <= 5) && (y <= 6);
          end
          1: begin
            sh_x[1] = x + 1;
            sh_y[1] = y - 1;
            sh_x[2] = x + 2;
            sh_fits = (x <= 5) && (y >= 1);
          end
          2: begin
            sh_x[1] = x + 1;
            sh_y[1] = y + 1;
            sh_y[2] = y + 2;
            sh_fits = (x <= 6) && (y <= 5);
          end
          default: begin
            sh_x[1] = x - 1;
            sh_y[1] = y + 1;
            sh_y[2] = y + 2;
            sh_fits = (x >= 1) && (y <= 5);
          end
        endcase
      end
      4: begin
        sh_n    = 1;
        sh_fits = 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic model_expect_place(input place_req_t req, output place_status_e st);
    int t;
    bit crosses;
    t       = int'(req.ship_type);
    crosses = 1'b0;
    model_shape(t, req.vertical, int'(req.orient), int'(req.anchor.x), int'(req.anchor.y));
    if (sh_fits) begin
      for (int i = 0; i < sh_n; i++) begin
        if (owner_m[sh_x[i]][sh_y[i]] >= 0) crosses = 1'b1;
      end
    end
    if (t > 4) st = place_bad_type;
    else if (!sh_fits) st = place_border;
    else if (placed_m[t]) st = place_duplicate;
    else if (crosses) st = place_overlap;
    else st = place_ok;
  endtask

  task automatic model_commit(input int t);
    for (int i = 0; i < sh_n; i++) owner_m[sh_x[i]][sh_y[i]] = t;
    placed_m[t] = 1'b1;
    remain_m[t] = sh_n;
  endtask

  task automatic model_shot(input cell_t c, output shot_rsp_t want);
    int  x;
    int  y;
    int  t;
    bit  all_gone;
    x = int'(c.x);
    y = int'(c.y);
    t = owner_m[x][y];
    if (shot_m[x][y]) begin
      want.result = shot_repeat;
    end else begin
      shot_m[x][y] = 1'b1;
      if (t < 0) begin
        want.result = shot_miss;
      end else begin
        remain_m[t]--;
        want.result = (remain_m[t] == 0) ? shot_sunk : shot_hit;
      end
    end
    all_gone = 1'b1;
    for (int i = 0; i < 5; i++) begin
      if (!placed_m[i] || remain_m[i] != 0) all_gone = 1'b0;
    end
    want.fleet_sunk = all_gone;
  endtask

  function automatic place_req_t make_req(int code, int v, int o, int x, int y);
    place_req_t r;
    r.ship_type = ship_type_e'(3'(code));
    r.vertical  = v[0];
    r.orient    = 2'(o);
    r.anchor.x  = coord_t'(x);
    r.anchor.y  = coord_t'(y);
    return r;
  endfunction

  function automatic place_req_t random_req(int code);
    return make_req(code, $urandom % 2, $urandom % 4, $urandom % 8, $urandom % 8);
  endfunction

  function automatic cell_t random_cell();
    cell_t c;
    c.x = coord_t'($urandom % 8);
    c.y = coord_t'($urandom % 8);
    return c;
  endfunction

  task automatic apply_reset();
    rst_n        = 1'b0;
    place_strobe = 1'b0;
    fire_strobe  = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    model_clear();
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    assert (!busy) else begin
      $display("Timeout: DUT stayed busy for %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  task automatic place_and_check(input string name, input place_req_t req);
    place_status_e want;
    place_status_e got;
    int            n;
    model_expect_place(req, want);
    wait_idle();
    place_req    = req;
    place_strobe = 1'b1;
    @(negedge clk);
    place_strobe = 1'b0;
    n = 1;
    while (!place_done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    got = place_status;
    checks++;
    assert (place_done) else begin
      $display("Timeout: no place_done in %s", name);
      errors++;
    end
    assert (n == 3) else begin
      $display("[FAIL] %s latency: expected 3, actual %0d", name, n);
      errors++;
    end
    assert (got == want) else begin
      $display("[FAIL] %s: expected %s, actual %s", name, want.name(), got.name());
      errors++;
    end
    if (want == place_ok) model_commit(int'(req.ship_type));
  endtask

  task automatic fire_and_check(input string name, input cell_t c);
    shot_rsp_t    want;
    shot_result_e want_res;
    shot_result_e got_res;
    int           n;
    model_shot(c, want);
    wait_idle();
    fire_cell   = c;
    fire_strobe = 1'b1;
    @(negedge clk);
    fire_strobe = 1'b0;
    n = 1;
    while (!shot_done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    last_rsp = shot_rsp;
    want_res = want.result;
    got_res  = last_rsp.result;
    checks++;
    assert (shot_done) else begin
      $display("Timeout: no shot_done in %s", name);
      errors++;
    end
    assert (n == 3) else begin
      $display("[FAIL] %s latency: expected 3, actual %0d", name, n);
      errors++;
    end
    assert (last_rsp == want) else begin
      $display("[FAIL] %s (%0d,%0d): expected %s/%0b, actual %s/%0b", name, c.x, c.y,
               want_res.name(), want.fleet_sunk, got_res.name(), last_rsp.fleet_sunk);
      errors++;
    end
  endtask

  // Extra strobes while busy, or both strobes in one cycle
  task automatic strobe_rule_test(input string name, input bit both_at_once);
    place_req_t    req;
    place_status_e want;
    place_status_e got;
    int            pd;
    int            sd;
    int            at;
    logic [11:0]   busy_seen;   // busy at each falling edge after the strobe
    req = random_req($urandom % 5);
    model_expect_place(req, want);
    wait_idle();
    pd           = 0;
    sd           = 0;
    at           = 0;
    busy_seen    = '0;
    got          = place_ok;
    place_req    = req;
    fire_cell    = random_cell();
    place_strobe = 1'b1;
    fire_strobe  = both_at_once;
    for (int i = 1; i <= 12; i++) begin
      @(negedge clk);
      place_strobe = !both_at_once && (i == 2);
      fire_strobe  = !both_at_once && (i == 1);
      busy_seen[i-1] = busy;
      if (place_done) begin
        pd++;
        at  = i;
        got = place_status;
      end
      if (shot_done) sd++;
    end
    checks++;
    assert (pd == 1 && sd == 0) else begin
      $display("[FAIL] %s done pulses: expected 1/0, actual %0d/%0d", name, pd, sd);
      errors++;
    end
    assert (at == 3) else begin
      $display("[FAIL] %s latency: expected 3, actual %0d", name, at);
      errors++;
    end
    // High from the cycle after the strobe through the done cycle
    assert (busy_seen == 12'h007) else begin
      $display("[FAIL] %s busy: expected %b, actual %b", name, 12'h007, busy_seen);
      errors++;
    end
    assert (got == want) else begin
      $display("[FAIL] %s: expected %s, actual %s", name, want.name(), got.name());
      errors++;
    end
    if (want == place_ok) model_commit(int'(req.ship_type));
  endtask

  task automatic fill_fleet();
    int tries;
    for (int t = 0; t < 5; t++) begin
      tries = 0;
      while (!placed_m[t] && tries < 200) begin
        place_and_check("fill_place", random_req(t));
        tries++;
      end
      assert (placed_m[t]) else begin
        $display("Ship type %0d could not be placed in %0d tries", t, tries);
        errors++;
      end
    end
  endtask

  task automatic sink_fleet();
    cell_t c;
    for (int y = 0; y < 8; y++) begin
      for (int x = 0; x < 8; x++) begin
        if (owner_m[x][y] >= 0 && !shot_m[x][y]) begin
          c.x = coord_t'(x);
          c.y = coord_t'(y);
          fire_and_check("fleet_shot", c);
        end
      end
    end
    checks++;
    assert (last_rsp.fleet_sunk) else begin
      $display("[FAIL] fleet_sunk_end: expected 1, actual %0b", last_rsp.fleet_sunk);
      errors++;
    end
  endtask

  initial begin
    int edge_vals [5];
    rst_n        = 1'b0;
    place_strobe = 1'b0;
    place_req    = '0;
    fire_strobe  = 1'b0;
    fire_cell    = '0;
    errors       = 0;
    checks       = 0;
    last_rsp     = '0;
    edge_vals    = '{0, 1, 5, 6, 7};
    void'($urandom(32'h8b58));

    apply_reset();
    checks++;
    assert (!busy && !place_done && !shot_done) else begin
      $display("[FAIL] reset_outputs: expected 000, actual %b%b%b", busy, place_done, shot_done);
      errors++;
    end
    fire_and_check("reset_shot", random_cell());
    apply_reset();   // Clears the shot map again

    // Seaplane orientations around every edge
    for (int o = 0; o < 4; o++) begin
      for (int xi = 0; xi < 5; xi++) begin
        for (int yi = 0; yi < 5; yi++) begin
          place_and_check("seaplane_edge",
                          make_req(2, $urandom % 2, o, edge_vals[xi], edge_vals[yi]));
        end
      end
    end
    for (int code = 5; code < 8; code++) place_and_check("bad_type", random_req(code));
    strobe_rule_test("busy_strobes", 1'b0);
    strobe_rule_test("same_cycle_strobes", 1'b1);
    for (int i = 0; i < 150; i++) place_and_check("random_place", random_req($urandom % 8));
    fill_fleet();
    for (int i = 0; i < 60; i++) fire_and_check("random_shot", random_cell());
    sink_fleet();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/battle_pkg.sv
source/ship_shape_gen.sv
source/occupancy_grid.sv
source/fleet_memory.sv
source/placement_ctrl.sv
source/shot_resolver.sv
source/battle_map_top.sv
dv/tb_clock_gen.sv
dv/battle_map_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the battle map testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module battle_map_tb -Mdir obj_dir -f all.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vbattle_map_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
